// File: Bender.yml
package:
  name: usbfs_tx

sources:
  - src/usbfs_pkg.sv
  - src/usb_tx_fifo.sv
  - src/usb_wb_regs.sv
  - src/usb_packetizer.sv
  - src/usb_line_tx.sv
  - src/usbfs_tx_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/usb_tx_tb.sv

// File: src/usb_line_tx.sv
/*
 NRZI serializer for full speed, one bit every BIT_PERIOD clocks, lsb first.
 A zero is stuffed after six ones, also ahead of the EOP.
 The packet ends when valid is low at a byte boundary.
*/
`timescale 1ns/10ps

module usb_line_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       valid,
  input  logic [7:0] data,
  output logic       rd,
  output logic       en,
  output logic       usb_p,
  output logic       usb_n
);

  localparam int TICK_W = $clog2(usbfs_pkg::BIT_PERIOD);

  logic [TICK_W-1:0] tick;     // clocks left in the current bit
  logic [2:0]        bits;     // data bits still in shift
  logic [2:0]        ones;     // run of ones on the line
  logic [7:0]        shift;
  logic [1:0]        line;
  logic [1:0]        line_tgl;
  logic              eop;
  logic [1:0]        eop_cnt;
  logic              tx_bit;

  assign line_tgl = (line == usbfs_pkg::LINE_J) ? usbfs_pkg::LINE_K : usbfs_pkg::LINE_J;
  assign tx_bit   = (bits != 3'd0) ? shift[0] : data[0];   // next data bit
  assign {usb_p, usb_n} = line;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd      <= 1'b0;
      en      <= 1'b0;
      tick    <= '0;
      bits    <= '0;
      ones    <= '0;
      shift   <= '0;
      line    <= usbfs_pkg::LINE_J;
      eop     <= 1'b0;
      eop_cnt <= '0;
    end
    else
    begin
      rd <= 1'b0;
      if (tick != '0)
        tick <= tick - 1'b1;
      else if (eop)
      begin
        // SE0 for two bits, J for one, then release
        case (eop_cnt)
          2'd1:
          begin
            tick    <= TICK_W'(usbfs_pkg::BIT_PERIOD - 1);
            line    <= usbfs_pkg::LINE_J;
            eop_cnt <= 2'd2;
          end
          2'd2:
          begin
            en      <= 1'b0;
            eop     <= 1'b0;
            eop_cnt <= 2'd0;
            ones    <= '0;
          end
          default:
          begin
            tick    <= TICK_W'(usbfs_pkg::BIT_PERIOD - 1);
            eop_cnt <= 2'd1;                 // second SE0 bit
          end
        endcase
      end
      else if (en && ones == 3'd6)
      begin
        tick <= TICK_W'(usbfs_pkg::BIT_PERIOD - 1);
        line <= line_tgl;                    // stuffed zero
        ones <= '0;
      end
      else if (bits != 3'd0 || valid)
      begin
        tick <= TICK_W'(usbfs_pkg::BIT_PERIOD - 1);
        if (bits != 3'd0)
        begin
          shift <= {1'b0, shift[7:1]};
          bits  <= bits - 1'b1;
        end
        else
        begin
          shift <= {1'b0, data[7:1]};        // take new byte
          bits  <= 3'd7;
          rd    <= 1'b1;
          en    <= 1'b1;
        end
        if (tx_bit)
          ones <= ones + 1'b1;               // one holds the line
        else
        begin
          line <= line_tgl;
          ones <= '0;
        end
      end
      else if (en)
      begin
        tick    <= TICK_W'(usbfs_pkg::BIT_PERIOD - 1);
        line    <= usbfs_pkg::LINE_SE0;      // first EOP bit
        eop     <= 1'b1;
        eop_cnt <= 2'd0;
      end
    end
  end

endmodule

// File: src/usb_packetizer.sv
/*
 Builds SYNC, PID, payload and CRC16 as a byte stream for the line transmitter.
 The byte count is the FIFO level at start; handshake PIDs carry no payload.
*/
`timescale 1ns/10ps

module usb_packetizer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic [3:0]                    pid,
  input  logic [7:0]                    head,
  input  logic [usbfs_pkg::LEVEL_W-1:0] level,
  input  logic                          rd,
  input  logic                          en,
  output logic                          pop,
  output logic                          valid,
  output logic [7:0]                    data,
  output logic                          busy
);

  usbfs_pkg::pkt_state_e         state;
  usbfs_pkg::pid_e               pid_q;
  logic [usbfs_pkg::LEVEL_W-1:0] count;      // payload bytes left
  logic [15:0]                   crc;
  logic                          is_data;

  // one byte of the reflected CRC16, lsb first
  function automatic logic [15:0] crc16_byte(input logic [15:0] crc_in, input logic [7:0] b);
    logic [15:0] c;
    c = crc_in ^ {8'h00, b};
    for (int i = 0; i < 8; i++)
    begin
      c = c[0] ? ((c >> 1) ^ usbfs_pkg::CRC16_POLY) : (c >> 1);
    end
    return c;
  endfunction

  assign is_data = (pid_q == usbfs_pkg::DATA0) || (pid_q == usbfs_pkg::DATA1);
  assign busy    = (state != usbfs_pkg::IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= usbfs_pkg::IDLE;
      pid_q <= usbfs_pkg::ACK;
      count <= '0;
      crc   <= 16'hFFFF;
      valid <= 1'b0;
      data  <= '0;
      pop   <= 1'b0;
    end
    else
    begin
      pop <= 1'b0;
      case (state)
        usbfs_pkg::IDLE:
          if (start)
          begin
            pid_q <= usbfs_pkg::pid_e'(pid);
            count <= level;                  // snapshot of queued payload
            crc   <= 16'hFFFF;
            data  <= usbfs_pkg::SYNC_BYTE;
            valid <= 1'b1;
            state <= usbfs_pkg::SYNC;
          end
        usbfs_pkg::SYNC:
          if (rd)
          begin
            data  <= {~pid_q, pid_q};        // check nibble on top
            state <= usbfs_pkg::PID;
          end
        usbfs_pkg::PID, usbfs_pkg::PAYLOAD:
          if (rd)
          begin
            if (!is_data)
            begin
              valid <= 1'b0;                 // handshake ends here
              state <= usbfs_pkg::WAIT_EOP;
            end
            else if (count != '0)
            begin
              data  <= head;
              pop   <= 1'b1;
              crc   <= crc16_byte(crc, head);
              count <= count - 1'b1;
              state <= usbfs_pkg::PAYLOAD;
            end
            else
            begin
              data  <= ~crc[7:0];            // low byte first
              state <= usbfs_pkg::CRC_LO;
            end
          end
        usbfs_pkg::CRC_LO:
          if (rd)
          begin
            data  <= ~crc[15:8];
            state <= usbfs_pkg::CRC_HI;
          end
        usbfs_pkg::CRC_HI:
          if (rd)
          begin
            valid <= 1'b0;
            state <= usbfs_pkg::WAIT_EOP;
          end
        usbfs_pkg::WAIT_EOP:
          if (!en)                           // EOP done on the line
            state <= usbfs_pkg::IDLE;
        default:
          state <= usbfs_pkg::IDLE;
      endcase
    end
  end

endmodule

// File: src/usb_tx_fifo.sv
/*
 Show-ahead payload FIFO, head is valid whenever level is non-zero.
 Pushes while full and pops while empty are dropped silently.
*/
`timescale 1ns/10ps

module usb_tx_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          push,
  input  logic [7:0]                    push_data,
  input  logic                          pop,
  output logic [7:0]                    head,
  output logic [usbfs_pkg::LEVEL_W-1:0] level
);

  logic [7:0]                    mem [usbfs_pkg::FIFO_DEPTH];
  logic [usbfs_pkg::LEVEL_W-2:0] wr_ptr;   // wraps at depth
  logic [usbfs_pkg::LEVEL_W-2:0] rd_ptr;
  logic                          do_push;
  logic                          do_pop;

  assign do_push = push && (level != usbfs_pkg::LEVEL_W'(usbfs_pkg::FIFO_DEPTH));
  assign do_pop  = pop && (level != '0);
  assign head    = mem[rd_ptr];                // oldest byte

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;           // none or both
      endcase
    end
  end

endmodule

// File: src/usb_wb_regs.sv
/*
 Wishbone classic slave, ack one cycle after cyc and stb, no wait states.
 A send write is dropped while the packetizer is busy.
*/
`timescale 1ns/10ps

module usb_wb_regs (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  logic [1:0]                    adr,
  input  logic [15:0]                   dat_i,
  input  logic                          busy,
  input  logic [usbfs_pkg::LEVEL_W-1:0] level,
  output logic [15:0]                   dat_o,
  output logic                          ack,
  output logic                          push,
  output logic [7:0]                    push_data,
  output logic                          start,
  output logic [3:0]                    pid
);

  logic req;
  logic wr_data;
  logic wr_ctrl;
  logic rd_status;

  assign req       = cyc && stb && !ack;     // new request, not yet acked
  assign wr_data   = req && we && (adr == usbfs_pkg::ADDR_DATA);
  assign wr_ctrl   = req && we && (adr == usbfs_pkg::ADDR_CTRL);
  assign rd_status = req && !we && (adr == usbfs_pkg::ADDR_STATUS);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack   <= 1'b0;
      push  <= 1'b0;
      start <= 1'b0;
      dat_o <= '0;
    end
    else
    begin
      ack   <= req;
      push  <= wr_data;
      start <= wr_ctrl && dat_i[8] && !busy;   // send strobe
      if (rd_status)
        dat_o <= {7'd0, busy, 2'd0, level};
      else
        dat_o <= '0;                         // DATA and CTRL read as zero
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_data)
      push_data <= dat_i[7:0];
    if (wr_ctrl)
      pid <= dat_i[3:0];
  end

endmodule

// File: src/usbfs_pkg.sv
/*
 Shared constants and types for the USB full-speed transmitter.
 Timing assumes a 48 MHz clock, 4 clocks per 12 Mbit/s bit.
*/
package usbfs_pkg;

  localparam int BIT_PERIOD = 4;                // 48 MHz / 12 Mbit/s
  localparam int FIFO_DEPTH = 32;               // payload bytes
  localparam int LEVEL_W    = 6;                // holds 0..FIFO_DEPTH

  // {usb_p, usb_n}
  localparam logic [1:0] LINE_J   = 2'b10;      // full speed idle
  localparam logic [1:0] LINE_K   = 2'b01;
  localparam logic [1:0] LINE_SE0 = 2'b00;

  localparam logic [7:0]  SYNC_BYTE  = 8'h80;   // KJKJKJKK on the wire
  localparam logic [15:0] CRC16_POLY = 16'hA001; // 0x8005 reflected

  localparam logic [1:0] ADDR_DATA   = 2'd0;
  localparam logic [1:0] ADDR_CTRL   = 2'd1;
  localparam logic [1:0] ADDR_STATUS = 2'd2;

  typedef enum logic [3:0] {
    DATA0 = 4'b0011,
    DATA1 = 4'b1011,
    ACK   = 4'b0010,
    NAK   = 4'b1010,
    STALL = 4'b1110
  } pid_e;

  typedef enum logic [2:0] {
    IDLE,
    SYNC,
    PID,
    PAYLOAD,
    CRC_LO,
    CRC_HI,
    WAIT_EOP
  } pkt_state_e;

endpackage

// File: src/usbfs_tx_top.sv
/*
 USB full-speed transmit path behind a Wishbone classic slave, 48 MHz clk.
 No receive path, tokens or low speed.
*/
`timescale 1ns/10ps

module usbfs_tx_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  logic [1:0]  adr,
  input  logic [15:0] dat_i,
  output logic [15:0] dat_o,
  output logic        ack,
  output logic        usb_p,
  output logic        usb_n,
  output logic        en
);

  logic                          push;
  logic [7:0]                    push_data;
  logic                          pop;
  logic [7:0]                    head;
  logic [usbfs_pkg::LEVEL_W-1:0] level;
  logic                          start;
  logic [3:0]                    pid;
  logic                          busy;
  logic                          valid;
  logic [7:0]                    data;
  logic                          rd;

  usb_wb_regs u_regs (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_i(dat_i), .busy(busy), .level(level), .dat_o(dat_o), .ack(ack),
    .push(push), .push_data(push_data), .start(start), .pid(pid)
  );

  usb_tx_fifo u_fifo (
    .clk(clk), .rst_n(rst_n), .push(push), .push_data(push_data),
    .pop(pop), .head(head), .level(level)
  );

  usb_packetizer u_pkt (
    .clk(clk), .rst_n(rst_n), .start(start), .pid(pid), .head(head),
    .level(level), .rd(rd), .en(en), .pop(pop), .valid(valid),
    .data(data), .busy(busy)
  );

  usb_line_tx u_line (
    .clk(clk), .rst_n(rst_n), .valid(valid), .data(data), .rd(rd),
    .en(en), .usb_p(usb_p), .usb_n(usb_n)
  );

endmodule

// File: testbench/usb_line_decode.svh
/*
 Line decoder and reference model, included inside the testbench module.
 The decoder assumes idle J before SYNC and samples at mid-bit from the rise of en.
*/
`ifndef USB_LINE_DECODE_SVH
`define USB_LINE_DECODE_SVH

typedef logic [7:0] byte_q [$];

// spec form of CRC16, msb-aligned register, data bits lsb first
// result bit k is the k-th CRC bit on the wire
function automatic logic [15:0] crc16_wire(input byte_q payload);
  logic [15:0] r;
  logic [15:0] w;
  logic        fb;
  r = 16'hFFFF;
  foreach (payload[i])
  begin
    for (int b = 0; b < 8; b++)
    begin
      fb = payload[i][b] ^ r[15];
      r  = {r[14:0], 1'b0} ^ (fb ? 16'h8005 : 16'h0000);
    end
  end
  for (int k = 0; k < 16; k++)
    w[k] = ~r[15 - k];                   // complement goes out msb first
  return w;
endfunction

function automatic byte_q expected_packet(input logic [3:0] pid, input byte_q payload,
                                          input bit is_data);
  byte_q       pkt;
  logic [15:0] w;
  pkt = {};
  pkt.push_back(8'h80);                  // SYNC, KJKJKJKK
  pkt.push_back({~pid, pid});
  if (is_data)
  begin
    foreach (payload[i])
      pkt.push_back(payload[i]);
    w = crc16_wire(payload);
    pkt.push_back(w[7:0]);
    pkt.push_back(w[15:8]);
  end
  return pkt;
endfunction

// stuffed zeros the line must carry for this byte stream
function automatic int count_stuffs(input byte_q pkt);
  int ones;
  int n;
  ones = 0;
  n    = 0;
  foreach (pkt[i])
  begin
    for (int b = 0; b < 8; b++)
    begin
      ones = pkt[i][b] ? ones + 1 : 0;
      if (ones == 6)
      begin
        n++;
        ones = 0;
      end
    end
  end
  return n;
endfunction

task automatic decode_packet(output byte_q got, output int stuffs);
  logic [1:0] prev;
  logic [1:0] cur;
  logic [7:0] sr;
  int         nbits;
  int         ones;
  int         wait_n;
  bit         rx;
  got    = {};
  stuffs = 0;
  prev   = usbfs_pkg::LINE_J;
  sr     = '0;
  nbits  = 0;
  ones   = 0;
  wait_n = 0;
  do
  begin
    @(negedge clk);
    wait_n++;
  end
  while (!en && wait_n < 3);
  if (!en)
  begin
    report_error("en did not rise after the send write");
    return;
  end
  @(negedge clk);                        // middle of the first bit
  cur = {usb_p, usb_n};
  while (cur != usbfs_pkg::LINE_SE0)
  begin
    rx   = (cur == prev);                // no transition is a one
    prev = cur;
    if (ones == 6)
    begin
      if (rx)
        report_error("missing stuffed zero after six ones");
      else
        stuffs++;
      ones = 0;
    end
    else
    begin
      sr    = {rx, sr[7:1]};
      nbits = nbits + 1;
      ones  = rx ? ones + 1 : 0;
      if (nbits % 8 == 0)
        got.push_back(sr);
    end
    repeat (usbfs_pkg::BIT_PERIOD) @(negedge clk);
    cur = {usb_p, usb_n};
  end
  if (nbits % 8 != 0)
    report_error("packet ended inside a byte");
  repeat (usbfs_pkg::BIT_PERIOD) @(negedge clk);
  compare("usb_p/usb_n in EOP bit 2", {usb_p, usb_n}, usbfs_pkg::LINE_SE0);
  repeat (usbfs_pkg::BIT_PERIOD) @(negedge clk);
  compare("usb_p/usb_n after SE0", {usb_p, usb_n}, usbfs_pkg::LINE_J);
  repeat (usbfs_pkg::BIT_PERIOD) @(negedge clk);
  compare("en after EOP", en, 0);
endtask

`endif

// File: testbench/usb_tx_tb.sv
/*
 Testbench for usbfs_tx_top, random payloads from a fixed xorshift seed.
 Payloads stay at 16 bytes or less so the FIFO never fills.
*/
`timescale 1ns/10ps

module usb_tx_tb;

  localparam int NUM_PKTS     = 12;          // packets in the run, rounded up
  localparam int MAX_PKT_BITS = 189;         // 20 bytes, stuffing and EOP
  localparam int TIMEOUT_CYC  = 4 * NUM_PKTS * MAX_PKT_BITS + 2000;

  logic        clk;
  logic        rst_n;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [1:0]  adr;
  logic [15:0] dat_i;
  logic [15:0] dat_o;
  logic        ack;
  logic        usb_p;
  logic        usb_n;
  logic        en;
  int          errors;
  int          checks;
  int          cycles;
  int          err0;
  int          n;
  logic [31:0] seed;
  logic [31:0] r;
  logic [15:0] rdata;

  usbfs_tx_top UUT (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_i(dat_i), .dat_o(dat_o), .ack(ack), .usb_p(usb_p), .usb_n(usb_n), .en(en)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_next();
    seed = xorshift(seed);
    return seed;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  `include "usb_line_decode.svh"

  byte_q fifo_model;                         // bytes queued in the DUT FIFO

  task automatic bus_access(input bit write, input logic [1:0] a, input logic [15:0] d,
                            output logic [15:0] q);
    int wait_n;
    @(negedge clk);
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = a;
    dat_i  = d;
    wait_n = 0;
    do
    begin
      @(negedge clk);
      wait_n++;
    end
    while (!ack && wait_n < 16);
    if (!ack)
      report_error("no Wishbone ack within 16 cycles");
    q   = dat_o;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic push_byte(input logic [7:0] b);
    logic [15:0] q;
    bus_access(1'b1, usbfs_pkg::ADDR_DATA, {8'h00, b}, q);
    fifo_model.push_back(b);
  endtask

  task automatic send_packet(input logic [3:0] pid, input bit second_send);
    byte_q       exp;
    byte_q       got;
    byte_q       payload;
    int          stuffs;
    logic [15:0] q;
    bit          is_data;
    is_data = (pid == usbfs_pkg::DATA0) || (pid == usbfs_pkg::DATA1);
    payload = fifo_model;
    exp     = expected_packet(pid, payload, is_data);
    bus_access(1'b1, usbfs_pkg::ADDR_CTRL, 16'h0100 | pid, q);
    fork
      decode_packet(got, stuffs);
      begin
        bus_access(1'b0, usbfs_pkg::ADDR_STATUS, 16'h0000, q);
        compare("status busy during packet", q[8], 1);
        if (second_send)
          bus_access(1'b1, usbfs_pkg::ADDR_CTRL, 16'h0100 | usbfs_pkg::DATA1, q);
      end
    join
    compare("decoded byte count", got.size(), exp.size());
    foreach (exp[i])
    begin
      if (i < got.size())
        compare($sformatf("decoded byte %0d", i), got[i], exp[i]);
    end
    compare("stuffed bits", stuffs, count_stuffs(exp));
    if (is_data)
      fifo_model = {};
    bus_access(1'b0, usbfs_pkg::ADDR_STATUS, 16'h0000, q);
    compare("status busy after packet", q[8], 0);
    compare("status level after packet", q[5:0], fifo_model.size());
  endtask

  task automatic report_test(input string name, input int err_start);
    if (errors == err_start)
      $display("%s: ok", name);
    else
      $display("%s: %0d errors", name, errors - err_start);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                   // 125 MHz sim clock, 4 per bit
  end

  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYC)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a packet or bus cycle never finished", cycles);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    rst_n  = 1'b0;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = 2'd0;
    dat_i  = 16'h0000;
    errors = 0;
    checks = 0;
    seed   = 32'h7551;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    err0 = errors;
    @(negedge clk);
    compare("en", en, 0);
    compare("usb_p/usb_n", {usb_p, usb_n}, usbfs_pkg::LINE_J);
    bus_access(1'b0, usbfs_pkg::ADDR_STATUS, 16'h0000, rdata);
    compare("status", rdata, 0);
    report_test("reset state", err0);

    err0 = errors;
    n    = 1 + rand_next() % 8;
    for (int i = 0; i < n; i++)
    begin
      r = rand_next();
      push_byte(r[7:0]);
      bus_access(1'b0, usbfs_pkg::ADDR_STATUS, 16'h0000, rdata);
      compare("status level", rdata[5:0], fifo_model.size());
    end
    report_test("fifo level", err0);

    err0 = errors;
    send_packet(usbfs_pkg::ACK, 1'b0);       // queued payload stays put
    send_packet(usbfs_pkg::NAK, 1'b0);
    send_packet(usbfs_pkg::STALL, 1'b0);
    report_test("handshake packets", err0);

    err0 = errors;
    repeat (6)
    begin
      r = rand_next();
      n = r % 17;
      while (fifo_model.size() < n)
      begin
        r = rand_next();
        push_byte(r[7:0]);
      end
      send_packet(r[8] ? usbfs_pkg::DATA1 : usbfs_pkg::DATA0, 1'b0);
    end
    report_test("data packets", err0);

    err0 = errors;
    repeat (16) push_byte(8'hFF);
    send_packet(usbfs_pkg::DATA0, 1'b0);
    report_test("bit stuffing", err0);

    err0 = errors;
    send_packet(usbfs_pkg::NAK, 1'b1);
    n = 0;
    repeat (64)
    begin
      @(negedge clk);
      if (en)
        n++;
    end
    if (n != 0)
      report_error("a send write made while busy started a second packet");
    report_test("send while busy", err0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: usbfs_tx.f
+incdir+testbench
src/usbfs_pkg.sv
src/usb_tx_fifo.sv
src/usb_wb_regs.sv
src/usb_packetizer.sv
src/usb_line_tx.sv
src/usbfs_tx_top.sv
testbench/usb_tx_tb.sv
